//--- fabric_node.f
+incdir+src
src/fabric_pkg.sv
src/fabric_decode_gate.sv
src/fabric_req_queue.sv
src/fabric_mem_slave.sv
src/fabric_node.sv
verif/fabric_node_asserts.sv
verif/fabric_node_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the fabric node testbench with Verilator and run it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f fabric_node.f \
    --top-module fabric_node_tb -o fabric_node_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fabric_node_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

echo "Simulation ended cleanly"
exit 0

//--- src/fabric_config.svh
////////////////////
// Fabric node configuration macros.
// Bus widths, address window and memory depth.
////////////////////

`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// Bus widths in bits.
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32
`define FABRIC_ID_W 4

// Address window of the node.
// A request is in range when (addr & mask) == base.
`define FABRIC_ADDR_BASE 32'h0000_1000
`define FABRIC_ADDR_MASK 32'hFFFF_F000

// Depth of the memory slave in words.
`define FABRIC_MEM_WORDS 64

`endif

//--- src/fabric_decode_gate.sv
////////////////////
// Decode gate for the upstream port.
// Window check, pass-through and decode error responses.
// Allows one transaction in flight.
////////////////////

`include "fabric_config.svh"

module fabric_decode_gate (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fabric_pkg::fabric_req_t up_req,
  input  logic                    up_req_valid,
  output logic                    up_req_ready,
  output fabric_pkg::fabric_req_t dn_req,
  output logic                    dn_req_valid,
  input  logic                    dn_req_ready,
  input  fabric_pkg::fabric_rsp_t dn_rsp,
  input  logic                    dn_rsp_valid,
  output logic                    dn_rsp_ready,
  output fabric_pkg::fabric_rsp_t up_rsp,
  output logic                    up_rsp_valid,
  input  logic                    up_rsp_ready
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_e;

  state_e                  state_q;
  logic                    err_q;
  logic [`FABRIC_ID_W-1:0] err_id_q;
  logic                    in_range;
  logic                    req_fire;
  logic                    rsp_fire;

  assign in_range = (up_req.addr & `FABRIC_ADDR_MASK) == `FABRIC_ADDR_BASE;

  // Payload goes straight through, only valid is qualified.
  assign dn_req = up_req;

  always_comb begin
    dn_req_valid = 1'b0;
    up_req_ready = 1'b0;
    up_rsp_valid = 1'b0;
    up_rsp       = '0;
    dn_rsp_ready = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (in_range) begin
          dn_req_valid = up_req_valid;
          up_req_ready = dn_req_ready;
        end else begin
          // Out-of-range requests are taken here and never reach the queue.
          up_req_ready = 1'b1;
        end
      end

      ST_WAIT: begin
        if (err_q) begin
          up_rsp_valid = 1'b1;
          up_rsp.rdata = '0;
          up_rsp.code  = fabric_pkg::RESP_DECODE_ERR;
          up_rsp.id    = err_id_q;
        end else begin
          up_rsp_valid = dn_rsp_valid;
          up_rsp       = dn_rsp;
          dn_rsp_ready = up_rsp_ready;
        end
      end

      default: begin
      end
    endcase
  end

  assign req_fire = up_req_valid && up_req_ready;
  assign rsp_fire = up_rsp_valid && up_rsp_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_fire) begin
            state_q <= ST_WAIT;
            err_q   <= !in_range;
          end
        end
        ST_WAIT: begin
          // Upstream transfer closes the transaction.
          if (rsp_fire) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Id of the rejected request, returned with the error.
  always_ff @(posedge clk) begin
    if (req_fire && !in_range) begin
      err_id_q <= up_req.id;
    end
  end

endmodule

//--- src/fabric_mem_slave.sv
////////////////////
// Word-addressed memory slave.
// Reads, byte-strobed writes, one registered response per request.
////////////////////

`include "fabric_config.svh"

module fabric_mem_slave (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fabric_pkg::fabric_req_t req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output fabric_pkg::fabric_rsp_t rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready
);

  localparam int unsigned STRB_W = `FABRIC_DATA_W / 8;
  localparam int unsigned OFF_W  = $clog2(STRB_W);
  localparam int unsigned IDX_W  = $clog2(`FABRIC_MEM_WORDS);

  logic [`FABRIC_DATA_W-1:0] mem [`FABRIC_MEM_WORDS];
  logic [IDX_W-1:0]          idx;
  logic                      req_fire;
  logic                      rsp_valid_q;
  fabric_pkg::fabric_rsp_t   rsp_q;

  // Word index, wraps modulo the depth.
  assign idx = req.addr[OFF_W +: IDX_W];

  // A new request is taken only once the held response is gone.
  assign req_ready = !rsp_valid_q;
  assign req_fire  = req_valid && req_ready;

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Byte-merged write.
  always_ff @(posedge clk) begin
    if (req_fire && req.op == fabric_pkg::OP_WRITE) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Response built at accept and held until taken.
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_q.id <= req.id;
      case (req.op)
        fabric_pkg::OP_READ: begin
          rsp_q.rdata <= mem[idx];
          rsp_q.code  <= fabric_pkg::RESP_OK;
        end
        fabric_pkg::OP_WRITE: begin
          rsp_q.rdata <= '0;
          rsp_q.code  <= fabric_pkg::RESP_OK;
        end
        default: begin
          rsp_q.rdata <= '0;
          rsp_q.code  <= fabric_pkg::RESP_BAD_OP;
        end
      endcase
    end
  end

endmodule

//--- src/fabric_node.sv
////////////////////
// Fabric node top level.
// Decode gate, request queue and memory slave.
////////////////////

module fabric_node (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fabric_pkg::fabric_req_t up_req,
  input  logic                    up_req_valid,
  output logic                    up_req_ready,
  output fabric_pkg::fabric_rsp_t up_rsp,
  output logic                    up_rsp_valid,
  input  logic                    up_rsp_ready
);

  // Gate to queue.
  fabric_pkg::fabric_req_t gate_req;
  logic                    gate_req_valid;
  logic                    queue_in_ready;

  // Queue to slave.
  fabric_pkg::fabric_req_t mem_req;
  logic                    mem_req_valid;
  logic                    mem_req_ready;

  // Slave back to gate, unbuffered.
  fabric_pkg::fabric_rsp_t mem_rsp;
  logic                    mem_rsp_valid;
  logic                    mem_rsp_ready;

  fabric_decode_gate gate_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .up_req       (up_req),
    .up_req_valid (up_req_valid),
    .up_req_ready (up_req_ready),
    .dn_req       (gate_req),
    .dn_req_valid (gate_req_valid),
    .dn_req_ready (queue_in_ready),
    .dn_rsp       (mem_rsp),
    .dn_rsp_valid (mem_rsp_valid),
    .dn_rsp_ready (mem_rsp_ready),
    .up_rsp       (up_rsp),
    .up_rsp_valid (up_rsp_valid),
    .up_rsp_ready (up_rsp_ready)
  );

  fabric_req_queue queue_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (gate_req),
    .in_valid  (gate_req_valid),
    .in_ready  (queue_in_ready),
    .out_req   (mem_req),
    .out_valid (mem_req_valid),
    .out_ready (mem_req_ready)
  );

  fabric_mem_slave mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (mem_req),
    .req_valid (mem_req_valid),
    .req_ready (mem_req_ready),
    .rsp       (mem_rsp),
    .rsp_valid (mem_rsp_valid),
    .rsp_ready (mem_rsp_ready)
  );

endmodule

//--- src/fabric_pkg.sv
////////////////////
// Fabric package.
// Opcode and response code enums, request and response structs.
////////////////////

`include "fabric_config.svh"

package fabric_pkg;

  // Request opcodes; codes 2 and 3 are not supported by the slave.
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_RSVD2 = 2'd2,
    OP_RSVD3 = 2'd3
  } fabric_op_e;

  // Response codes.
  typedef enum logic [1:0] {
    RESP_OK         = 2'd0,
    RESP_DECODE_ERR = 2'd1,
    RESP_BAD_OP     = 2'd2
  } fabric_resp_e;

  // Request payload, one strobe bit per data byte.
  typedef struct packed {
    fabric_op_e                   op;
    logic [`FABRIC_ADDR_W-1:0]    addr;
    logic [`FABRIC_DATA_W-1:0]    wdata;
    logic [`FABRIC_DATA_W/8-1:0]  wstrb;
    logic [`FABRIC_ID_W-1:0]      id;
  } fabric_req_t;

  // Response payload.
  typedef struct packed {
    logic [`FABRIC_DATA_W-1:0] rdata;
    fabric_resp_e              code;
    logic [`FABRIC_ID_W-1:0]   id;
  } fabric_rsp_t;

endpackage

//--- src/fabric_req_queue.sv
////////////////////
// Two-entry request FIFO.
// Sits between the decode gate and the memory slave.
////////////////////

module fabric_req_queue (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fabric_pkg::fabric_req_t in_req,
  input  logic                    in_valid,
  output logic                    in_ready,
  output fabric_pkg::fabric_req_t out_req,
  output logic                    out_valid,
  input  logic                    out_ready
);

  fabric_pkg::fabric_req_t store_q [2];
  logic                    wr_ptr_q;
  logic                    rd_ptr_q;
  logic [1:0]              count_q;
  logic                    push;
  logic                    pop;

  // Full when both entries hold a request.
  assign in_ready  = count_q != 2'd2;
  assign out_valid = count_q != 2'd0;
  assign out_req   = store_q[rd_ptr_q];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage.
  always_ff @(posedge clk) begin
    if (push) begin
      store_q[wr_ptr_q] <= in_req;
    end
  end

endmodule

//--- verif/fabric_node_asserts.sv
////////////////////
// Handshake assertions on the upstream port.
// Bound into the fabric node top level.
////////////////////

module fabric_node_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input fabric_pkg::fabric_req_t up_req,
  input logic                    up_req_valid,
  input logic                    up_req_ready,
  input fabric_pkg::fabric_rsp_t up_rsp,
  input logic                    up_rsp_valid,
  input logic                    up_rsp_ready
);

  // Set from request accept until the response transfers.
  logic busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (up_req_valid && up_req_ready) begin
      busy_q <= 1'b1;
    end else if (up_rsp_valid && up_rsp_ready) begin
      busy_q <= 1'b0;
    end
  end

  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    up_req_valid && !up_req_ready |=> up_req_valid && $stable(up_req))
    else $error("upstream request dropped or changed before transfer");

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    up_rsp_valid && !up_rsp_ready |=> up_rsp_valid && $stable(up_rsp))
    else $error("upstream response dropped or changed before transfer");

  no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy_q |-> !up_req_ready)
    else $error("request ready raised while a response is outstanding");

endmodule

bind fabric_node fabric_node_asserts asserts_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .up_req       (up_req),
  .up_req_valid (up_req_valid),
  .up_req_ready (up_req_ready),
  .up_rsp       (up_rsp),
  .up_rsp_valid (up_rsp_valid),
  .up_rsp_ready (up_rsp_ready)
);

//--- verif/fabric_node_tb.sv
////////////////////
// Testbench for the fabric node.
// Clock, reset, reference memory, directed tests, timeout.
////////////////////

`include "fabric_config.svh"

module fabric_node_tb;

  // About 100 transactions of under 10 cycles each plus a wide margin.
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                      clk;
  logic                      rst_n;
  fabric_pkg::fabric_req_t   up_req;
  logic                      up_req_valid;
  logic                      up_req_ready;
  fabric_pkg::fabric_rsp_t   up_rsp;
  logic                      up_rsp_valid;
  logic                      up_rsp_ready;
  logic [`FABRIC_DATA_W-1:0] ref_mem [`FABRIC_MEM_WORDS];
  int unsigned               cycle_cnt = 0;

  fabric_node dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .up_req       (up_req),
    .up_req_valid (up_req_valid),
    .up_req_ready (up_req_ready),
    .up_rsp       (up_rsp),
    .up_rsp_valid (up_rsp_valid),
    .up_rsp_ready (up_rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "check failed");
    end
  endtask

  // Word index in the slave, modulo the memory depth.
  function automatic int unsigned word_index(logic [31:0] addr);
    return (addr >> 2) % `FABRIC_MEM_WORDS;
  endfunction

  function automatic fabric_pkg::fabric_req_t make_req(fabric_pkg::fabric_op_e op,
      logic [31:0] addr, logic [31:0] wdata, logic [3:0] wstrb, logic [3:0] id);
    fabric_pkg::fabric_req_t req;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    req.id    = id;
    return req;
  endfunction

  // Runs one transaction and is called on a falling edge.
  // The response is held off for stall cycles once it turns valid.
  task automatic run_req(input string name, input fabric_pkg::fabric_req_t req,
                         input int unsigned stall, output fabric_pkg::fabric_rsp_t rsp);
    int unsigned held;
    held         = 0;
    up_req       = req;
    up_req_valid = 1'b1;
    #1;
    while (!up_req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    up_req_valid = 1'b0;
    while (!(up_rsp_valid && held == stall)) begin
      if (up_rsp_valid) held++;
      check_value({name, " ready while busy"}, 32'd0, 32'(up_req_ready));
      @(negedge clk);
    end
    rsp          = up_rsp;
    up_rsp_ready = 1'b1;
    @(negedge clk);
    up_rsp_ready = 1'b0;
  endtask

  task automatic expect_rsp(string name, fabric_pkg::fabric_rsp_t rsp,
      fabric_pkg::fabric_resp_e code, logic [3:0] id, logic [31:0] rdata);
    check_value({name, " code"}, 32'(code), 32'(rsp.code));
    check_value({name, " id"}, 32'(id), 32'(rsp.id));
    check_value({name, " rdata"}, rdata, rsp.rdata);
  endtask

  task automatic do_write(string name, logic [31:0] addr, logic [31:0] data,
                          logic [3:0] strb, logic [3:0] id);
    fabric_pkg::fabric_rsp_t rsp;
    run_req(name, make_req(fabric_pkg::OP_WRITE, addr, data, strb, id), 0, rsp);
    expect_rsp(name, rsp, fabric_pkg::RESP_OK, id, 32'd0);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[word_index(addr)][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic do_read(string name, logic [31:0] addr, logic [3:0] id, int unsigned stall);
    fabric_pkg::fabric_rsp_t rsp;
    run_req(name, make_req(fabric_pkg::OP_READ, addr, 32'd0, 4'd0, id), stall, rsp);
    expect_rsp(name, rsp, fabric_pkg::RESP_OK, id, ref_mem[word_index(addr)]);
  endtask

  // Every word gets a known value first.
  task automatic fill_memory();
    logic [31:0] addr;
    for (int i = 0; i < `FABRIC_MEM_WORDS; i++) begin
      addr = `FABRIC_ADDR_BASE + 32'(i * 4);
      do_write("fill", addr, addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f, 4'hF, 4'(i));
    end
  endtask

  task automatic test_word_rw();
    do_write("word_rw write", 32'h0000_1010, 32'hdead_beef, 4'hF, 4'd3);
    do_read("word_rw read", 32'h0000_1010, 4'd7, 0);
  endtask

  task automatic test_strobe_merge();
    do_write("strobe full", 32'h0000_1024, 32'h1122_3344, 4'hF, 4'd1);
    do_write("strobe partial", 32'h0000_1024, 32'haabb_ccdd, 4'b0101, 4'd2);
    do_read("strobe read", 32'h0000_1024, 4'd9, 0);
  endtask

  // Same low bits as an in-range word so that a leak shows on the read.
  task automatic test_decode_err();
    fabric_pkg::fabric_rsp_t rsp;
    run_req("decode_err",
            make_req(fabric_pkg::OP_WRITE, 32'h0000_2010, 32'hffff_ffff, 4'hF, 4'd5),
            0, rsp);
    expect_rsp("decode_err", rsp, fabric_pkg::RESP_DECODE_ERR, 4'd5, 32'd0);
    do_read("decode_err read", 32'h0000_1010, 4'd6, 0);
  endtask

  task automatic test_bad_op();
    fabric_pkg::fabric_rsp_t rsp;
    run_req("bad_op",
            make_req(fabric_pkg::OP_RSVD3, 32'h0000_1030, 32'h1234_5678, 4'hF, 4'd11),
            0, rsp);
    expect_rsp("bad_op", rsp, fabric_pkg::RESP_BAD_OP, 4'd11, 32'd0);
  endtask

  task automatic test_rsp_stall();
    fabric_pkg::fabric_rsp_t rsp;
    for (int i = 0; i < 4; i++) begin
      do_read("stall read", 32'h0000_1010 + 32'(i * 4), 4'(i), $urandom % 6);
    end
    run_req("stall decode_err",
            make_req(fabric_pkg::OP_READ, 32'h0001_0000, 32'd0, 4'd0, 4'd12),
            $urandom % 6, rsp);
    expect_rsp("stall decode_err", rsp, fabric_pkg::RESP_DECODE_ERR, 4'd12, 32'd0);
  endtask

  task automatic test_random();
    logic [31:0] addr;
    for (int i = 0; i < 20; i++) begin
      addr = `FABRIC_ADDR_BASE | ($urandom & 32'h0000_0ffc);
      if ($urandom % 2 == 0) begin
        do_write("random write", addr, $urandom, 4'($urandom), 4'($urandom));
      end else begin
        do_read("random read", addr, 4'($urandom), 0);
      end
    end
  endtask

  initial begin
    void'($urandom(32'he98c));
    rst_n        = 1'b0;
    up_req       = '0;
    up_req_valid = 1'b0;
    up_rsp_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    fill_memory();
    test_word_rw();
    test_strobe_merge();
    test_decode_err();
    test_bad_op();
    test_rsp_stall();
    test_random();
    $display("All tests passed!");
    $finish;
  end

endmodule
